// File: hdl/devtbl.sv
`timescale 1ns/1ps
`default_nettype none

module devtbl (
	input wire logic clk_2x_w,
	input wire logic rst_p,
	pi1_if.slv bus,
	output logic warm_rst_o
);

	logic [pi1_pkg::DATA_W-1:0] id_tbl [soc_dev_pkg::SLOT_COUNT];
	logic [pi1_pkg::DATA_W-1:0] size_tbl [soc_dev_pkg::SLOT_COUNT];
	logic [3:0] off;
	logic req;
	logic is_wr;
	logic rdy_q;
	logic [pi1_pkg::DATA_W-1:0] rdata_q;
	logic [pi1_pkg::DATA_W-1:0] rd_mux;
	logic [soc_dev_pkg::RST_CNTR_W-1:0] rst_cntr_q;

	// Slot order follows slot_t
	assign id_tbl[pi1_pkg::SLOT_DEVTBL] = soc_dev_pkg::DEV_ID_DEVTBL;
	assign id_tbl[pi1_pkg::SLOT_GPIO] = soc_dev_pkg::DEV_ID_GPIO;
	assign id_tbl[pi1_pkg::SLOT_INTCTRL] = soc_dev_pkg::DEV_ID_INTCTRL;
	assign id_tbl[pi1_pkg::SLOT_INVALID] = soc_dev_pkg::DEV_ID_INVALID;
	assign size_tbl[pi1_pkg::SLOT_DEVTBL] = pi1_pkg::DEVTBL_SPAN;
	assign size_tbl[pi1_pkg::SLOT_GPIO] = pi1_pkg::GPIO_SPAN;
	assign size_tbl[pi1_pkg::SLOT_INTCTRL] = pi1_pkg::INTCTRL_SPAN;
	assign size_tbl[pi1_pkg::SLOT_INVALID] = soc_dev_pkg::INVALID_SPAN;

	assign off = bus.addr[3:0];
	assign req = (bus.op != pi1_pkg::PI1_NOP) && !rdy_q;
	assign is_wr = (bus.op == pi1_pkg::PI1_WR) || (bus.op == pi1_pkg::PI1_RDWR);

	always_comb begin
		if (int'(off) < soc_dev_pkg::SLOT_COUNT)
			rd_mux = id_tbl[off[1:0]];
		else if (int'(off) < 2 * soc_dev_pkg::SLOT_COUNT)
			rd_mux = size_tbl[off[1:0]];
		else if (off == 4'hf)
			rd_mux = {{(pi1_pkg::DATA_W-1){1'b0}}, warm_rst_o};
		else
			rd_mux = '0;
	end

	always_ff @(posedge clk_2x_w) begin
		if (rst_p)
			rdy_q <= 1'b0;
		else
			rdy_q <= req;
		if (req)
			rdata_q <= rd_mux;
	end

	// Reset register takes effect at the edge that completes the write
	always_ff @(posedge clk_2x_w) begin
		if (rst_p)
			rst_cntr_q <= '0;
		else if (rdy_q && is_wr && off == 4'hf && bus.sel[0] && bus.wdata[0])
			rst_cntr_q <= soc_dev_pkg::RST_CNTR_W'(soc_dev_pkg::RST_HOLD_CYCLES);
		else if (rst_cntr_q != '0)
			rst_cntr_q <= rst_cntr_q - 1'b1;
	end

	assign warm_rst_o = (rst_cntr_q != '0);
	assign bus.rdy = rdy_q;
	assign bus.rdata = rdata_q;

endmodule

`default_nettype wire

// File: hdl/gpio.sv
`timescale 1ns/1ps
`default_nettype none

module gpio (
	input wire logic clk_2x_w,
	input wire logic rst_p,
	input wire logic warm_rst_i,
	pi1_if.slv bus,
	input wire logic [soc_dev_pkg::GPIO_COUNT-1:0] gp_i,
	output logic [soc_dev_pkg::GPIO_COUNT-1:0] gp_o,
	output logic intrqst_o
);

	logic [soc_dev_pkg::GPIO_COUNT-1:0] sync1_q;
	logic [soc_dev_pkg::GPIO_COUNT-1:0] in_q;
	logic [soc_dev_pkg::GPIO_COUNT-1:0] prev_q;
	logic [soc_dev_pkg::GPIO_COUNT-1:0] out_q;
	logic [soc_dev_pkg::GPIO_COUNT-1:0] mask_q;
	logic [soc_dev_pkg::GPIO_COUNT-1:0] rd_mux;
	logic [pi1_pkg::DATA_W-1:0] rdata_q;
	logic rdy_q;
	logic req;
	logic wr;
	logic reg_rst;

	assign reg_rst = rst_p || warm_rst_i;
	assign req = (bus.op != pi1_pkg::PI1_NOP) && !rdy_q;
	assign wr = req && bus.sel[0] &&
		((bus.op == pi1_pkg::PI1_WR) || (bus.op == pi1_pkg::PI1_RDWR));

	// Two-flop input synchronizer plus a history stage for edge detect
	always_ff @(posedge clk_2x_w) begin
		if (rst_p) begin
			sync1_q <= '0;
			in_q <= '0;
			prev_q <= '0;
		end else begin
			sync1_q <= gp_i;
			in_q <= sync1_q;
			prev_q <= in_q;
		end
	end

	always_ff @(posedge clk_2x_w) begin
		if (reg_rst) begin
			out_q <= '0;
			mask_q <= '0;
		end else if (wr && bus.addr == 10'd1) begin
			out_q <= bus.wdata[soc_dev_pkg::GPIO_COUNT-1:0];
		end else if (wr && bus.addr == 10'd2) begin
			mask_q <= bus.wdata[soc_dev_pkg::GPIO_COUNT-1:0];
		end
	end

	always_comb begin
		case (bus.addr)
			10'd0: rd_mux = in_q;
			10'd1: rd_mux = out_q;
			10'd2: rd_mux = mask_q;
			default: rd_mux = '0;
		endcase
	end

	// Read data is captured before the write lands, which gives RDWR its old value
	always_ff @(posedge clk_2x_w) begin
		if (rst_p)
			rdy_q <= 1'b0;
		else
			rdy_q <= req;
		if (req)
			rdata_q <= {{(pi1_pkg::DATA_W-soc_dev_pkg::GPIO_COUNT){1'b0}}, rd_mux};
	end

	assign intrqst_o = |((in_q ^ prev_q) & mask_q);
	assign gp_o = out_q;
	assign bus.rdy = rdy_q;
	assign bus.rdata = rdata_q;

endmodule

`default_nettype wire

// File: hdl/intctrl.sv
`timescale 1ns/1ps
`default_nettype none

module intctrl (
	input wire logic clk_2x_w,
	input wire logic rst_p,
	input wire logic warm_rst_i,
	pi1_if.slv bus,
	input wire logic [soc_dev_pkg::INTSRC_COUNT-1:0] src_i,
	output logic irq_o
);

	logic [soc_dev_pkg::INTSRC_COUNT-1:0] pend_q;
	logic [soc_dev_pkg::INTSRC_COUNT-1:0] en_q;
	logic [soc_dev_pkg::INTSRC_COUNT-1:0] clr;
	logic [soc_dev_pkg::INTSRC_COUNT-1:0] rd_mux;
	logic [pi1_pkg::DATA_W-1:0] rdata_q;
	logic rdy_q;
	logic req;
	logic wr;

	assign req = (bus.op != pi1_pkg::PI1_NOP) && !rdy_q;
	assign wr = req && bus.sel[0] &&
		((bus.op == pi1_pkg::PI1_WR) || (bus.op == pi1_pkg::PI1_RDWR));

	// Write one to clear, a new pulse in the same cycle wins
	assign clr = (wr && bus.addr == 10'd0) ?
		bus.wdata[soc_dev_pkg::INTSRC_COUNT-1:0] : '0;

	always_ff @(posedge clk_2x_w) begin
		if (rst_p || warm_rst_i) begin
			pend_q <= '0;
			en_q <= '0;
		end else begin
			pend_q <= (pend_q & ~clr) | src_i;
			if (wr && bus.addr == 10'd1)
				en_q <= bus.wdata[soc_dev_pkg::INTSRC_COUNT-1:0];
		end
	end

	assign rd_mux = (bus.addr == 10'd0) ? pend_q : (bus.addr == 10'd1) ? en_q : '0;

	always_ff @(posedge clk_2x_w) begin
		if (rst_p)
			rdy_q <= 1'b0;
		else
			rdy_q <= req;
		if (req)
			rdata_q <= {{(pi1_pkg::DATA_W-soc_dev_pkg::INTSRC_COUNT){1'b0}}, rd_mux};
	end

	assign irq_o = |(pend_q & en_q);
	assign bus.rdy = rdy_q;
	assign bus.rdata = rdata_q;

endmodule

`default_nettype wire

// File: hdl/pi1_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module pi1_arbiter (
	input wire logic clk_2x_w,
	input wire logic rst_p,
	pi1_if.slv m0_bus,
	pi1_if.slv m1_bus,
	pi1_if.mst sys_bus
);

	typedef enum logic {
		ARB_IDLE,
		ARB_BUSY
	} arb_state_t;

	arb_state_t state_q;
	// Granted master, 0 for m0 and 1 for m1
	logic gnt_q;
	logic last_q;
	logic req0;
	logic req1;
	logic pick;
	logic busy;

	assign req0 = (m0_bus.op != pi1_pkg::PI1_NOP);
	assign req1 = (m1_bus.op != pi1_pkg::PI1_NOP);
	assign busy = (state_q == ARB_BUSY);

	// On a tie the master not served last wins
	always_comb begin
		if (req0 && req1)
			pick = ~last_q;
		else
			pick = req1;
	end

	always_ff @(posedge clk_2x_w) begin
		if (rst_p) begin
			state_q <= ARB_IDLE;
			gnt_q <= 1'b0;
			last_q <= 1'b1;
		end else begin
			case (state_q)
				ARB_IDLE: begin
					if (req0 || req1) begin
						state_q <= ARB_BUSY;
						gnt_q <= pick;
					end
				end
				ARB_BUSY: begin
					// Release in the same edge that completes the transfer
					if (sys_bus.rdy) begin
						state_q <= ARB_IDLE;
						last_q <= gnt_q;
					end
				end
				default: state_q <= ARB_IDLE;
			endcase
		end
	end

	assign sys_bus.op = busy ? (gnt_q ? m1_bus.op : m0_bus.op) : pi1_pkg::PI1_NOP;
	assign sys_bus.addr = gnt_q ? m1_bus.addr : m0_bus.addr;
	assign sys_bus.wdata = gnt_q ? m1_bus.wdata : m0_bus.wdata;
	assign sys_bus.sel = gnt_q ? m1_bus.sel : m0_bus.sel;

	// Responses go back to the granted master only
	assign m0_bus.rdy = busy && !gnt_q && sys_bus.rdy;
	assign m1_bus.rdy = busy && gnt_q && sys_bus.rdy;
	assign m0_bus.rdata = (busy && !gnt_q) ? sys_bus.rdata : '0;
	assign m1_bus.rdata = (busy && gnt_q) ? sys_bus.rdata : '0;

endmodule

`default_nettype wire

// File: hdl/pi1_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module pi1_decoder (
	input wire logic clk_2x_w,
	input wire logic rst_p,
	pi1_if.slv sys_bus,
	pi1_if.mst devtbl_bus,
	pi1_if.mst gpio_bus,
	pi1_if.mst intctrl_bus
);

	pi1_pkg::slot_t slot;
	logic inv_rdy_q;

	function automatic logic in_win(input int a, input int base, input int span);
		return (a >= base) && (a < base + span);
	endfunction

	always_comb begin
		if (in_win(int'(sys_bus.addr), int'(pi1_pkg::DEVTBL_BASE), pi1_pkg::DEVTBL_SPAN))
			slot = pi1_pkg::SLOT_DEVTBL;
		else if (in_win(int'(sys_bus.addr), int'(pi1_pkg::GPIO_BASE), pi1_pkg::GPIO_SPAN))
			slot = pi1_pkg::SLOT_GPIO;
		else if (in_win(int'(sys_bus.addr), int'(pi1_pkg::INTCTRL_BASE),
				pi1_pkg::INTCTRL_SPAN))
			slot = pi1_pkg::SLOT_INTCTRL;
		else
			slot = pi1_pkg::SLOT_INVALID;
	end

	// Only the selected slave sees a live op
	assign devtbl_bus.op = (slot == pi1_pkg::SLOT_DEVTBL) ? sys_bus.op : pi1_pkg::PI1_NOP;
	assign gpio_bus.op = (slot == pi1_pkg::SLOT_GPIO) ? sys_bus.op : pi1_pkg::PI1_NOP;
	assign intctrl_bus.op = (slot == pi1_pkg::SLOT_INTCTRL) ? sys_bus.op : pi1_pkg::PI1_NOP;

	assign devtbl_bus.addr = sys_bus.addr - pi1_pkg::DEVTBL_BASE;
	assign gpio_bus.addr = sys_bus.addr - pi1_pkg::GPIO_BASE;
	assign intctrl_bus.addr = sys_bus.addr - pi1_pkg::INTCTRL_BASE;

	assign devtbl_bus.wdata = sys_bus.wdata;
	assign gpio_bus.wdata = sys_bus.wdata;
	assign intctrl_bus.wdata = sys_bus.wdata;
	assign devtbl_bus.sel = sys_bus.sel;
	assign gpio_bus.sel = sys_bus.sel;
	assign intctrl_bus.sel = sys_bus.sel;

	// Invalid-device responder, one cycle and rdata zero
	always_ff @(posedge clk_2x_w) begin
		if (rst_p)
			inv_rdy_q <= 1'b0;
		else
			inv_rdy_q <= (slot == pi1_pkg::SLOT_INVALID) &&
				(sys_bus.op != pi1_pkg::PI1_NOP) && !inv_rdy_q;
	end

	always_comb begin
		case (slot)
			pi1_pkg::SLOT_DEVTBL: begin
				sys_bus.rdy = devtbl_bus.rdy;
				sys_bus.rdata = devtbl_bus.rdata;
			end
			pi1_pkg::SLOT_GPIO: begin
				sys_bus.rdy = gpio_bus.rdy;
				sys_bus.rdata = gpio_bus.rdata;
			end
			pi1_pkg::SLOT_INTCTRL: begin
				sys_bus.rdy = intctrl_bus.rdy;
				sys_bus.rdata = intctrl_bus.rdata;
			end
			default: begin
				sys_bus.rdy = inv_rdy_q;
				sys_bus.rdata = '0;
			end
		endcase
	end

endmodule

`default_nettype wire

// File: hdl/pi1_if.sv
`timescale 1ns/1ps
`default_nettype none

interface pi1_if;

	// Request fields, held by the master until rdy
	pi1_pkg::pi1_op_t op;
	logic [pi1_pkg::ADDR_W-1:0] addr;
	logic [pi1_pkg::DATA_W-1:0] wdata;
	logic [pi1_pkg::SEL_W-1:0] sel;

	// Response, rdata valid in the rdy cycle
	logic [pi1_pkg::DATA_W-1:0] rdata;
	logic rdy;

	modport mst (
		output op, addr, wdata, sel,
		input rdata, rdy
	);

	modport slv (
		input op, addr, wdata, sel,
		output rdata, rdy
	);

endinterface

`default_nettype wire

// File: hdl/pi1_pkg.sv
`default_nettype none

package pi1_pkg;

	// Bus geometry, word addressed
	localparam int DATA_W = 32;
	localparam int SEL_W = DATA_W / 8;
	localparam int ADDR_W = 10;

	// Bus opcodes, RDWR swaps the old word out for the new one
	typedef enum logic [1:0] {
		PI1_NOP  = 2'b00,
		PI1_WR   = 2'b01,
		PI1_RD   = 2'b10,
		PI1_RDWR = 2'b11
	} pi1_op_t;

	// Word address map
	localparam logic [ADDR_W-1:0] DEVTBL_BASE = 10'h000;
	localparam logic [ADDR_W-1:0] GPIO_BASE = 10'h010;
	localparam logic [ADDR_W-1:0] INTCTRL_BASE = 10'h020;

	localparam int DEVTBL_SPAN = 16;
	localparam int GPIO_SPAN = 4;
	localparam int INTCTRL_SPAN = 4;

	// Decoder target, also the slot order of the device table
	typedef enum logic [1:0] {
		SLOT_DEVTBL  = 2'd0,
		SLOT_GPIO    = 2'd1,
		SLOT_INTCTRL = 2'd2,
		SLOT_INVALID = 2'd3
	} slot_t;

endpackage

`default_nettype wire

// File: hdl/soc_dev_pkg.sv
`default_nettype none

package soc_dev_pkg;

	// Entries in the device table
	localparam int SLOT_COUNT = 4;

	// Device IDs as reported by the device table
	localparam logic [pi1_pkg::DATA_W-1:0] DEV_ID_DEVTBL = 32'd7;
	localparam logic [pi1_pkg::DATA_W-1:0] DEV_ID_GPIO = 32'd6;
	localparam logic [pi1_pkg::DATA_W-1:0] DEV_ID_INTCTRL = 32'd3;
	localparam logic [pi1_pkg::DATA_W-1:0] DEV_ID_INVALID = 32'd0;

	// Unmapped space is covered by the invalid-device responder
	localparam int INVALID_SPAN = 1024;

	localparam int GPIO_COUNT = 8;

	// Interrupt source indices
	localparam int INTSRC_GPIO = 0;
	localparam int INTSRC_EXT = 1;
	localparam int INTSRC_COUNT = 2;

	// Software warm reset length in clk_2x_w cycles
	localparam int RST_HOLD_CYCLES = 16;
	localparam int RST_CNTR_W = 5;

endpackage

`default_nettype wire

// File: hdl/soc_top.sv
`timescale 1ns/1ps
`default_nettype none

module soc_top (
	input wire logic clk_2x_w,
	input wire logic rst_p,
	input wire pi1_pkg::pi1_op_t m0_op_i,
	input wire logic [pi1_pkg::ADDR_W-1:0] m0_addr_i,
	input wire logic [pi1_pkg::DATA_W-1:0] m0_wdata_i,
	input wire logic [pi1_pkg::SEL_W-1:0] m0_sel_i,
	output logic [pi1_pkg::DATA_W-1:0] m0_rdata_o,
	output logic m0_rdy_o,
	input wire pi1_pkg::pi1_op_t m1_op_i,
	input wire logic [pi1_pkg::ADDR_W-1:0] m1_addr_i,
	input wire logic [pi1_pkg::DATA_W-1:0] m1_wdata_i,
	input wire logic [pi1_pkg::SEL_W-1:0] m1_sel_i,
	output logic [pi1_pkg::DATA_W-1:0] m1_rdata_o,
	output logic m1_rdy_o,
	input wire logic [soc_dev_pkg::GPIO_COUNT-1:0] gp_i,
	input wire logic ext_irq_i,
	output logic [soc_dev_pkg::GPIO_COUNT-1:0] gp_o,
	output logic irq_o
);

	pi1_if m0_bus ();
	pi1_if m1_bus ();
	pi1_if sys_bus ();
	pi1_if devtbl_bus ();
	pi1_if gpio_bus ();
	pi1_if intctrl_bus ();

	logic warm_rst;
	logic gpio_irq;
	logic [soc_dev_pkg::INTSRC_COUNT-1:0] int_src;

	// Plain master ports onto the bus interfaces
	assign m0_bus.op = m0_op_i;
	assign m0_bus.addr = m0_addr_i;
	assign m0_bus.wdata = m0_wdata_i;
	assign m0_bus.sel = m0_sel_i;
	assign m0_rdata_o = m0_bus.rdata;
	assign m0_rdy_o = m0_bus.rdy;
	assign m1_bus.op = m1_op_i;
	assign m1_bus.addr = m1_addr_i;
	assign m1_bus.wdata = m1_wdata_i;
	assign m1_bus.sel = m1_sel_i;
	assign m1_rdata_o = m1_bus.rdata;
	assign m1_rdy_o = m1_bus.rdy;

	assign int_src[soc_dev_pkg::INTSRC_GPIO] = gpio_irq;
	assign int_src[soc_dev_pkg::INTSRC_EXT] = ext_irq_i;

	pi1_arbiter u_arbiter (.clk_2x_w(clk_2x_w), .rst_p(rst_p),
		.m0_bus(m0_bus), .m1_bus(m1_bus), .sys_bus(sys_bus));

	pi1_decoder u_decoder (.clk_2x_w(clk_2x_w), .rst_p(rst_p), .sys_bus(sys_bus),
		.devtbl_bus(devtbl_bus), .gpio_bus(gpio_bus), .intctrl_bus(intctrl_bus));

	devtbl u_devtbl (.clk_2x_w(clk_2x_w), .rst_p(rst_p), .bus(devtbl_bus),
		.warm_rst_o(warm_rst));

	gpio u_gpio (.clk_2x_w(clk_2x_w), .rst_p(rst_p), .warm_rst_i(warm_rst),
		.bus(gpio_bus), .gp_i(gp_i), .gp_o(gp_o), .intrqst_o(gpio_irq));

	intctrl u_intctrl (.clk_2x_w(clk_2x_w), .rst_p(rst_p), .warm_rst_i(warm_rst),
		.bus(intctrl_bus), .src_i(int_src), .irq_o(irq_o));

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps -Wno-fatal \
	--top-module soc_tb -f sim.f --Mdir obj_dir -o soc_sim

./obj_dir/soc_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "^>>> PASS$" sim.log; then
	echo "Simulation passed"
else
	echo "Simulation failed"
	exit 1
fi

// File: sim.f
hdl/pi1_pkg.sv
hdl/soc_dev_pkg.sv
hdl/pi1_if.sv
hdl/pi1_arbiter.sv
hdl/pi1_decoder.sv
hdl/devtbl.sv
hdl/gpio.sv
hdl/intctrl.sv
hdl/soc_top.sv
tests/soc_tb.sv

// File: tests/soc_tb.sv
`timescale 1ns/1ps
`default_nettype none

module soc_tb;

	localparam int NUM_STEPS = 16;

	typedef struct packed {
		logic mst;
		pi1_pkg::pi1_op_t op;
		logic [9:0] addr;
		logic [31:0] wdata;
		logic [3:0] sel;
		logic [31:0] exp_rdata;
		logic [7:0] exp_gp;
	} step_t;

	logic clk_2x_w = 1'b0;
	logic rst_p;
	pi1_pkg::pi1_op_t m0_op;
	pi1_pkg::pi1_op_t m1_op;
	logic [9:0] m0_addr;
	logic [9:0] m1_addr;
	logic [31:0] m0_wdata;
	logic [31:0] m1_wdata;
	logic [3:0] m0_sel;
	logic [3:0] m1_sel;
	logic [31:0] m0_rdata;
	logic [31:0] m1_rdata;
	logic m0_rdy;
	logic m1_rdy;
	logic [7:0] gp_i;
	logic ext_irq;
	logic [7:0] gp_o;
	logic irq_o;

	step_t steps [NUM_STEPS];
	logic [31:0] lcg_state = 32'd34876;
	int m0_done_cnt = 0;
	int m1_done_cnt = 0;

	soc_top uut (
		.clk_2x_w(clk_2x_w), .rst_p(rst_p),
		.m0_op_i(m0_op), .m0_addr_i(m0_addr), .m0_wdata_i(m0_wdata), .m0_sel_i(m0_sel),
		.m0_rdata_o(m0_rdata), .m0_rdy_o(m0_rdy),
		.m1_op_i(m1_op), .m1_addr_i(m1_addr), .m1_wdata_i(m1_wdata), .m1_sel_i(m1_sel),
		.m1_rdata_o(m1_rdata), .m1_rdy_o(m1_rdy),
		.gp_i(gp_i), .ext_irq_i(ext_irq), .gp_o(gp_o), .irq_o(irq_o)
	);

	always #2 clk_2x_w = ~clk_2x_w;

	// Completions per master sampled at the falling edge
	always @(negedge clk_2x_w) begin
		if (m0_rdy)
			m0_done_cnt <= m0_done_cnt + 1;
		if (m1_rdy)
			m1_done_cnt <= m1_done_cnt + 1;
	end

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	task automatic check_value(input string name, input logic [31:0] exp,
		input logic [31:0] act);
		if (act !== exp) begin
			$display("** Error %s: expected 0x%08h, actual 0x%08h", name, exp, act);
			$display(">>> FAIL");
			$fatal(1, "value mismatch");
		end
	endtask

	task automatic idle_cycles(input int n);
		repeat (n) @(posedge clk_2x_w);
		#1;
	endtask

	task automatic drive_master(input logic mst, input pi1_pkg::pi1_op_t op,
		input logic [9:0] addr, input logic [31:0] wdata, input logic [3:0] sel);
		if (mst) begin
			m1_op = op;
			m1_addr = addr;
			m1_wdata = wdata;
			m1_sel = sel;
		end else begin
			m0_op = op;
			m0_addr = addr;
			m0_wdata = wdata;
			m0_sel = sel;
		end
	endtask

	// Starts 1 ns after a rising edge and returns at the same point
	task automatic bus_xfer(input logic mst, input pi1_pkg::pi1_op_t op,
		input logic [9:0] addr, input logic [31:0] wdata, input logic [3:0] sel,
		output logic [31:0] rdata);
		drive_master(mst, op, addr, wdata, sel);
		do
			@(negedge clk_2x_w);
		while (!(mst ? m1_rdy : m0_rdy));
		rdata = mst ? m1_rdata : m0_rdata;
		idle_cycles(1);
		drive_master(mst, pi1_pkg::PI1_NOP, '0, '0, '0);
	endtask

	task automatic wait_irq(output logic seen);
		int k;
		seen = 1'b0;
		for (k = 0; k < 5 && !seen; k++) begin
			@(negedge clk_2x_w);
			seen = irq_o;
		end
		idle_cycles(1);
	endtask

	task automatic fill_table();
		// mst, op, addr, wdata, sel, rdata expected, gp_o after the step
		steps[0] = '{1'b0, pi1_pkg::PI1_RD, 10'h000, 32'h0, 4'hf, 32'd7, 8'h00};
		steps[1] = '{1'b1, pi1_pkg::PI1_RD, 10'h001, 32'h0, 4'hf, 32'd6, 8'h00};
		steps[2] = '{1'b0, pi1_pkg::PI1_RD, 10'h002, 32'h0, 4'hf, 32'd3, 8'h00};
		steps[3] = '{1'b1, pi1_pkg::PI1_RD, 10'h003, 32'h0, 4'hf, 32'd0, 8'h00};
		steps[4] = '{1'b0, pi1_pkg::PI1_RD, 10'h004, 32'h0, 4'hf, 32'd16, 8'h00};
		steps[5] = '{1'b1, pi1_pkg::PI1_RD, 10'h005, 32'h0, 4'hf, 32'd4, 8'h00};
		steps[6] = '{1'b0, pi1_pkg::PI1_RD, 10'h006, 32'h0, 4'hf, 32'd4, 8'h00};
		steps[7] = '{1'b0, pi1_pkg::PI1_RD, 10'h007, 32'h0, 4'hf, 32'd1024, 8'h00};
		// Unmapped space answers zero
		steps[8] = '{1'b1, pi1_pkg::PI1_RD, 10'h123, 32'h0, 4'hf, 32'd0, 8'h00};
		steps[9] = '{1'b0, pi1_pkg::PI1_RD, 10'h3ff, 32'h0, 4'hf, 32'd0, 8'h00};
		steps[10] = '{1'b0, pi1_pkg::PI1_WR, 10'h011, 32'ha5, 4'h1, 32'd0, 8'ha5};
		steps[11] = '{1'b0, pi1_pkg::PI1_RD, 10'h011, 32'h0, 4'hf, 32'ha5, 8'ha5};
		// Output holds when byte 0 is not enabled
		steps[12] = '{1'b1, pi1_pkg::PI1_WR, 10'h011, 32'h3c, 4'he, 32'd0, 8'ha5};
		steps[13] = '{1'b1, pi1_pkg::PI1_RD, 10'h011, 32'h0, 4'hf, 32'ha5, 8'ha5};
		steps[14] = '{1'b0, pi1_pkg::PI1_RDWR, 10'h011, 32'h5a, 4'h1, 32'ha5, 8'h5a};
		steps[15] = '{1'b0, pi1_pkg::PI1_RD, 10'h011, 32'h0, 4'hf, 32'h5a, 8'h5a};
	endtask

	initial begin
		repeat (NUM_STEPS * 20 + 500) @(posedge clk_2x_w);
		$display("Run timed out before the tests finished");
		$display(">>> FAIL");
		$fatal(1, "watchdog expired");
	end

	initial begin
		int i;
		int cnt0;
		int cnt1;
		int first_mst;
		int m0_at_m1;
		logic [31:0] rd;
		logic [31:0] rd0;
		logic [31:0] rd1;
		logic [7:0] gp_val;
		logic seen;
		rst_p = 1'b1;
		drive_master(1'b0, pi1_pkg::PI1_NOP, '0, '0, '0);
		drive_master(1'b1, pi1_pkg::PI1_NOP, '0, '0, '0);
		gp_i = '0;
		ext_irq = 1'b0;
		fill_table();
		repeat (3) @(posedge clk_2x_w);
		#1;
		rst_p = 1'b0;
		@(negedge clk_2x_w);
		check_value("reset m0_rdy", 32'd0, {31'd0, m0_rdy});
		check_value("reset m1_rdy", 32'd0, {31'd0, m1_rdy});
		check_value("reset gp_o", 32'd0, {24'd0, gp_o});
		check_value("reset irq_o", 32'd0, {31'd0, irq_o});
		idle_cycles(1);

		for (i = 0; i < NUM_STEPS; i++) begin
			bus_xfer(steps[i].mst, steps[i].op, steps[i].addr, steps[i].wdata,
				steps[i].sel, rd);
			if (steps[i].op == pi1_pkg::PI1_RD || steps[i].op == pi1_pkg::PI1_RDWR)
				check_value($sformatf("step %0d rdata", i), steps[i].exp_rdata, rd);
			check_value($sformatf("step %0d gp_o", i), {24'd0, steps[i].exp_gp},
				{24'd0, gp_o});
		end

		// GPIO input through the synchronizer
		for (i = 0; i < 3; i++) begin
			lcg_state = lcg_next(lcg_state);
			gp_val = lcg_state[23:16];
			gp_i = gp_val;
			idle_cycles(4);
			bus_xfer(1'b0, pi1_pkg::PI1_RD, 10'h010, '0, 4'hf, rd);
			check_value($sformatf("gpio input %0d", i), {24'd0, gp_val}, rd);
		end

		// GPIO change interrupt and its clear
		bus_xfer(1'b0, pi1_pkg::PI1_WR, 10'h012, 32'hff, 4'h1, rd);
		bus_xfer(1'b1, pi1_pkg::PI1_WR, 10'h021, 32'h3, 4'h1, rd);
		bus_xfer(1'b1, pi1_pkg::PI1_RD, 10'h021, '0, 4'hf, rd);
		check_value("enable readback", 32'h3, rd);
		lcg_state = lcg_next(lcg_state);
		gp_val = lcg_state[23:16];
		if (gp_val == gp_i)
			gp_val = ~gp_val;
		gp_i = gp_val;
		wait_irq(seen);
		check_value("gpio irq rise", 32'd1, {31'd0, seen});
		bus_xfer(1'b0, pi1_pkg::PI1_RD, 10'h020, '0, 4'hf, rd);
		check_value("gpio pending", 32'h1, rd);
		bus_xfer(1'b0, pi1_pkg::PI1_WR, 10'h020, 32'h1, 4'h1, rd);
		check_value("gpio irq cleared", 32'd0, {31'd0, irq_o});

		// External source pulse
		ext_irq = 1'b1;
		idle_cycles(1);
		ext_irq = 1'b0;
		wait_irq(seen);
		check_value("ext irq rise", 32'd1, {31'd0, seen});
		bus_xfer(1'b1, pi1_pkg::PI1_RD, 10'h020, '0, 4'hf, rd);
		check_value("ext pending", 32'h2, rd);
		bus_xfer(1'b1, pi1_pkg::PI1_WR, 10'h020, 32'h2, 4'h1, rd);
		check_value("ext irq cleared", 32'd0, {31'd0, irq_o});

		// m1 wins the tie because m0 was served last
		bus_xfer(1'b0, pi1_pkg::PI1_RD, 10'h000, '0, 4'hf, rd);
		cnt0 = m0_done_cnt;
		cnt1 = m1_done_cnt;
		first_mst = -1;
		m0_at_m1 = -1;
		fork
			begin
				bus_xfer(1'b0, pi1_pkg::PI1_RD, 10'h002, '0, 4'hf, rd0);
				if (first_mst < 0)
					first_mst = 0;
			end
			begin
				bus_xfer(1'b1, pi1_pkg::PI1_RD, 10'h011, '0, 4'hf, rd1);
				m0_at_m1 = m0_done_cnt - cnt0;
				if (first_mst < 0)
					first_mst = 1;
			end
		join
		check_value("arb m0 rdata", 32'd3, rd0);
		check_value("arb m1 rdata", 32'h5a, rd1);
		check_value("arb first master", 32'd1, first_mst);
		check_value("arb m0 before m1", 32'd0, m0_at_m1);
		check_value("arb m0 completions", 32'd1, m0_done_cnt - cnt0);
		check_value("arb m1 completions", 32'd1, m1_done_cnt - cnt1);

		// Software warm reset
		bus_xfer(1'b0, pi1_pkg::PI1_WR, 10'h00f, 32'h1, 4'h1, rd);
		bus_xfer(1'b1, pi1_pkg::PI1_RD, 10'h00f, '0, 4'hf, rd);
		check_value("warm reset active", 32'h1, rd);
		idle_cycles(20);
		check_value("warm reset gp_o", 32'd0, {24'd0, gp_o});
		bus_xfer(1'b0, pi1_pkg::PI1_RD, 10'h011, '0, 4'hf, rd);
		check_value("warm reset gpio out", 32'd0, rd);
		bus_xfer(1'b0, pi1_pkg::PI1_RD, 10'h021, '0, 4'hf, rd);
		check_value("warm reset enable", 32'd0, rd);
		bus_xfer(1'b1, pi1_pkg::PI1_RD, 10'h00f, '0, 4'hf, rd);
		check_value("warm reset done", 32'd0, rd);
		bus_xfer(1'b1, pi1_pkg::PI1_RD, 10'h001, '0, 4'hf, rd);
		check_value("read after warm reset", 32'd6, rd);

		$display(">>> PASS");
		$finish;
	end

endmodule

`default_nettype wire
